/* hdl/mat_config.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MAT_N must be a power of two and divisible by LANES
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef MAT_CONFIG_SVH
`define MAT_CONFIG_SVH

// matrix order, both operands are square
`define MAT_N 4

// signed operand element width in bits
`define ELEM_W 8

// number of dot-product lanes working on one entry
// each lane covers MAT_N/LANES terms of the dot product
`define LANES 2

`endif

/* hdl/mat_types_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// all data types are signed two's complement, matrices row-major
// result entries are wide enough for MAT_N = 4 full-range products
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "mat_config.svh"

package mat_types_pkg;

	// one operand element
	typedef logic signed [`ELEM_W-1:0] elem_t;

	// product of two operand elements
	typedef logic signed [2*`ELEM_W-1:0] prod_t;

	// sum of the products one lane covers
	typedef logic signed [2*`ELEM_W:0] part_t;

	// one entry of the result matrix
	typedef logic signed [2*`ELEM_W+1:0] res_elem_t;

	// one job, element r*MAT_N+c holds row r, column c
	typedef struct packed {
		elem_t [`MAT_N*`MAT_N-1:0] a;
		elem_t [`MAT_N*`MAT_N-1:0] b;
	} mat_in_t;

	// product matrix, same row-major layout as the operands
	typedef struct packed {
		res_elem_t [`MAT_N*`MAT_N-1:0] c;
	} mat_res_t;

endpackage

/* hdl/mat_ctrl_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// entry index is {row, col}, so MAT_N must be a power of two
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "mat_config.svh"

package mat_ctrl_pkg;

	import mat_types_pkg::*;

	// bits needed for a row or a column number
	localparam int RC_W = $clog2(`MAT_N);

	typedef logic [RC_W-1:0] rc_t;

	// result entry index, row in the upper half
	typedef logic [2*RC_W-1:0] idx_t;

	// index of the last result entry of a job
	localparam idx_t LAST_IDX = idx_t'(`MAT_N*`MAT_N-1);

	// one entry handed to every lane
	typedef struct packed {
		logic valid;
		idx_t idx;
		elem_t [`MAT_N-1:0] row_a;
		elem_t [`MAT_N-1:0] col_b;
	} lane_issue_t;

	// partial dot product coming back from a lane
	typedef struct packed {
		logic valid;
		idx_t idx;
		part_t sum;
	} lane_part_t;

	typedef enum logic [1:0] {IDLE, ISSUE, WAIT_REQ_LOW} seq_state_t;

	typedef enum logic [1:0] {COLLECT, OFFER, WAIT_ACK_LOW} asm_state_t;

endpackage

/* hdl/mat_sequencer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// new job taken only while the assembler reports free
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "mat_config.svh"

module mat_sequencer
	import mat_types_pkg::*, mat_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        in_req,
	input  mat_in_t     in_job,
	input  logic        free,
	output logic        in_ack,
	output lane_issue_t issue
);

	seq_state_t state;
	idx_t       cnt;
	logic       accept;
	mat_in_t    op_q;

	rc_t row;
	rc_t col;

	elem_t [`MAT_N-1:0] row_sel;
	elem_t [`MAT_N-1:0] col_sel;

	logic               issue_vld;
	idx_t               issue_idx;
	elem_t [`MAT_N-1:0] row_q;
	elem_t [`MAT_N-1:0] col_q;

	assign accept = (state == IDLE) && in_req && free && !in_ack;

	assign {row, col} = cnt;

	// pick row of a and column of b for the current entry
	always_comb begin
		for (int k = 0; k < `MAT_N; k++) begin
			row_sel[k] = op_q.a[row * `MAT_N + k];
			col_sel[k] = op_q.b[k * `MAT_N + col];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= IDLE;
			in_ack    <= 1'b0;
			cnt       <= '0;
			issue_vld <= 1'b0;
		end else begin
			// ack falls once the host has released its request
			if (in_ack && !in_req) begin
				in_ack <= 1'b0;
			end
			issue_vld <= (state == ISSUE);
			case (state)
				IDLE: begin
					if (accept) begin
						in_ack <= 1'b1;
						cnt    <= '0;
						state  <= ISSUE;
					end
				end
				ISSUE: begin
					cnt <= cnt + 1'b1;
					if (cnt == LAST_IDX) begin
						state <= WAIT_REQ_LOW;
					end
				end
				WAIT_REQ_LOW: begin
					// a low ack means the request was already released
					// and in_req may carry the next job by now
					if (!in_req || !in_ack) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// operand store and issue payload
	always_ff @(posedge clk) begin
		if (accept) begin
			op_q <= in_job;
		end
		issue_idx <= cnt;
		row_q     <= row_sel;
		col_q     <= col_sel;
	end

	assign issue = '{valid: issue_vld, idx: issue_idx, row_a: row_q, col_b: col_q};

endmodule

/* hdl/dot_lane.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed 2-cycle latency, no stall input
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "mat_config.svh"

module dot_lane
	import mat_types_pkg::*, mat_ctrl_pkg::*;
#(
	// first term of the dot product this lane covers
	parameter int k_base = 0
) (
	input  logic        clk,
	input  logic        arst_n,
	input  lane_issue_t issue,
	output lane_part_t  part
);

	localparam int TERMS = `MAT_N / `LANES;

	// stage 1
	logic                s1_vld;
	idx_t                s1_idx;
	prod_t [TERMS-1:0]   s1_prod;

	// stage 2
	part_t sum_c;
	logic  s2_vld;
	idx_t  s2_idx;
	part_t s2_sum;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_vld <= 1'b0;
			s2_vld <= 1'b0;
		end else begin
			s1_vld <= issue.valid;
			s2_vld <= s1_vld;
		end
	end

	// products of this lane's share of the terms
	always_ff @(posedge clk) begin
		s1_idx <= issue.idx;
		for (int t = 0; t < TERMS; t++) begin
			s1_prod[t] <= issue.row_a[k_base + t] * issue.col_b[k_base + t];
		end
	end

	// adder tree is a plain chain for so few terms
	always_comb begin
		sum_c = '0;
		for (int t = 0; t < TERMS; t++) begin
			sum_c = sum_c + part_t'(s1_prod[t]);
		end
	end

	always_ff @(posedge clk) begin
		s2_idx <= s1_idx;
		s2_sum <= sum_c;
	end

	assign part = '{valid: s2_vld, idx: s2_idx, sum: s2_sum};

endmodule

/* hdl/mat_assembler.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// both lanes must deliver the same entry in the same cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module mat_assembler
	import mat_types_pkg::*, mat_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  lane_part_t part_lo,
	input  lane_part_t part_hi,
	input  logic       res_ack,
	output logic       res_req,
	output mat_res_t   res_data,
	output logic       free
);

	asm_state_t state;
	logic       store;
	res_elem_t  sum_c;
	mat_res_t   res_q;

	// lanes run in lockstep, lo lane supplies the index
	assign store = (state == COLLECT) && part_lo.valid && part_hi.valid;

	assign sum_c = res_elem_t'(part_lo.sum) + res_elem_t'(part_hi.sum);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= COLLECT;
			res_req <= 1'b0;
			free    <= 1'b1;
		end else begin
			case (state)
				COLLECT: begin
					if (store) begin
						free <= 1'b0;
						if (part_lo.idx == LAST_IDX) begin
							res_req <= 1'b1;
							state   <= OFFER;
						end
					end
				end
				OFFER: begin
					if (res_ack) begin
						res_req <= 1'b0;
						state   <= WAIT_ACK_LOW;
					end
				end
				WAIT_ACK_LOW: begin
					// host done, ready for the next job
					if (!res_ack) begin
						free  <= 1'b1;
						state <= COLLECT;
					end
				end
				default: state <= COLLECT;
			endcase
		end
	end

	// result matrix, written only while collecting
	always_ff @(posedge clk) begin
		if (store) begin
			res_q.c[part_lo.idx] <= sum_c;
		end
	end

	assign res_data = res_q;

endmodule

/* hdl/mat_mult_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// res_req follows in_ack by a fixed 19 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module mat_mult_top
	import mat_types_pkg::*, mat_ctrl_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     in_req,
	input  mat_in_t  in_job,
	input  logic     res_ack,
	output logic     in_ack,
	output logic     res_req,
	output mat_res_t res_data
);

	lane_issue_t issue;
	lane_part_t  part_lo;
	lane_part_t  part_hi;
	logic        free;

	mat_sequencer u_seq (
		.clk    (clk),
		.arst_n (arst_n),
		.in_req (in_req),
		.in_job (in_job),
		.free   (free),
		.in_ack (in_ack),
		.issue  (issue)
	);

	// lower half of the terms
	dot_lane #(.k_base(0)) u_lane_lo (
		.clk    (clk),
		.arst_n (arst_n),
		.issue  (issue),
		.part   (part_lo)
	);

	// upper half of the terms
	dot_lane #(.k_base(2)) u_lane_hi (
		.clk    (clk),
		.arst_n (arst_n),
		.issue  (issue),
		.part   (part_hi)
	);

	mat_assembler u_asm (
		.clk      (clk),
		.arst_n   (arst_n),
		.part_lo  (part_lo),
		.part_hi  (part_hi),
		.res_ack  (res_ack),
		.res_req  (res_req),
		.res_data (res_data),
		.free     (free)
	);

endmodule

/* tb/mat_mult_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// samples DUT ports on the falling clock edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "mat_config.svh"

module mat_mult_checker
	import mat_types_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     in_req,
	input  logic     in_ack,
	input  mat_in_t  in_job,
	input  logic     res_req,
	input  logic     res_ack,
	input  mat_res_t res_data,
	output int       mism_cnt,
	output int       proto_cnt,
	output int       res_cnt,
	output int       pending
);

	localparam int N = `MAT_N;
	localparam int LATENCY = 19;

	mat_in_t  job_q[$];
	int       start_q[$];
	int       cycle;
	int       lat;
	logic     seen_req;
	logic     busy;
	logic     prev_req;
	logic     prev_ack;
	logic     prev_rreq;
	logic     prev_rack;
	mat_in_t  prev_job;
	mat_res_t prev_data;

	// plain integer matrix product, row-major
	function automatic mat_res_t ref_product(input mat_in_t job);
		mat_res_t res;
		int       acc;
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				acc = 0;
				for (int k = 0; k < N; k++) begin
					acc += int'($signed(job.a[r*N+k])) * int'($signed(job.b[k*N+c]));
				end
				res.c[r*N+c] = res_elem_t'(acc);
			end
		end
		return res;
	endfunction

	task automatic compare_result(input mat_in_t job);
		mat_res_t exp_r;
		exp_r = ref_product(job);
		for (int i = 0; i < N*N; i++) begin
			if (res_data.c[i] !== exp_r.c[i]) begin
				$display("mismatch res_data[%0d][%0d] expected %h actual %h",
					i / N, i % N, exp_r.c[i], res_data.c[i]);
				mism_cnt++;
			end
		end
	endtask

	task automatic protocol_error(input string msg);
		$display("protocol error at %0t ns: %s", $time, msg);
		proto_cnt++;
	endtask

	always @(negedge clk) begin
		if (!arst_n) begin
			mism_cnt  = 0;
			proto_cnt = 0;
			res_cnt   = 0;
			pending   = 0;
			cycle     = 0;
			seen_req  = 1'b0;
			busy      = 1'b0;
			prev_req  = 1'b0;
			prev_ack  = 1'b0;
			prev_rreq = 1'b0;
			prev_rack = 1'b0;
			job_q.delete();
			start_q.delete();
		end else begin
			cycle++;
			if (!seen_req && (in_ack || res_req))
				protocol_error("in_ack or res_req high before any job was offered");
			if (in_req)
				seen_req = 1'b1;
			// prev values are what the DUT saw at the last rising edge
			if (in_ack && !prev_ack) begin
				if (!prev_req)
					protocol_error("in_ack rose while in_req was low");
				if (busy)
					protocol_error("new job acknowledged before the last result was returned");
				job_q.push_back(prev_job);
				start_q.push_back(cycle);
				busy = 1'b1;
			end
			if (res_req && !prev_rreq) begin
				if (job_q.size() == 0) begin
					protocol_error("res_req rose with no job outstanding");
				end else begin
					compare_result(job_q.pop_front());
					lat = cycle - start_q.pop_front();
					if (lat != LATENCY)
						protocol_error($sformatf("res_req rose %0d cycles after in_ack", lat));
					res_cnt++;
				end
			end
			if (!res_req && prev_rreq && !prev_rack)
				protocol_error("res_req fell before res_ack was high");
			if (res_req && prev_rreq && res_data !== prev_data)
				protocol_error("res_data changed while res_req was high");
			if (!res_ack && prev_rack)
				busy = 1'b0;
			pending   = job_q.size();
			prev_req  = in_req;
			prev_ack  = in_ack;
			prev_rreq = res_req;
			prev_rack = res_ack;
			prev_job  = in_job;
			prev_data = res_data;
		end
	end

endmodule

/* tb/mat_mult_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 3 directed jobs then 40 random ones, all stimulus built at time 0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "mat_config.svh"

module mat_mult_tb
	import mat_types_pkg::*;
();

	localparam int N          = `MAT_N;
	localparam int N_JOBS     = 43;
	localparam int RST_CYCLES = 3;
	localparam int WATCHDOG   = N_JOBS * 60 + 200;

	logic        clk = 1'b0;
	logic        arst_n;
	logic        in_req;
	mat_in_t     in_job;
	logic        res_ack;
	logic        in_ack;
	logic        res_req;
	mat_res_t    res_data;
	logic [31:0] lfsr;
	mat_in_t     jobs[N_JOBS];
	int          delays[N_JOBS];
	int          acked = 0;
	int          tb_errs;
	int          mism_cnt;
	int          proto_cnt;
	int          res_cnt;
	int          pending;

	always #2 clk = ~clk;

	mat_mult_top u_dut (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_req   (in_req),
		.in_job   (in_job),
		.res_ack  (res_ack),
		.in_ack   (in_ack),
		.res_req  (res_req),
		.res_data (res_data)
	);

	mat_mult_checker u_chk (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_req    (in_req),
		.in_ack    (in_ack),
		.in_job    (in_job),
		.res_req   (res_req),
		.res_ack   (res_ack),
		.res_data  (res_data),
		.mism_cnt  (mism_cnt),
		.proto_cnt (proto_cnt),
		.res_cnt   (res_cnt),
		.pending   (pending)
	);

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic build_jobs();
		for (int j = 0; j < N_JOBS; j++) begin
			for (int i = 0; i < N*N; i++) begin
				jobs[j].a[i] = elem_t'(rand_bits(`ELEM_W));
				jobs[j].b[i] = elem_t'(rand_bits(`ELEM_W));
			end
			delays[j] = int'(rand_bits(3));
		end
		// identity, zero and all -128 operands on the left
		for (int i = 0; i < N*N; i++) begin
			jobs[0].a[i] = (i / N == i % N) ? elem_t'(1) : elem_t'(0);
			jobs[2].a[i] = elem_t'(-128);
			jobs[2].b[i] = elem_t'(-128);
		end
		jobs[1].a = '0;
	endtask

	task automatic send_job(input mat_in_t job);
		in_job = job;
		in_req = 1'b1;
		do begin
			@(posedge clk);
			#1;
		end while (!in_ack);
		in_req = 1'b0;
		while (in_ack) begin
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		arst_n  = 1'b0;
		in_req  = 1'b0;
		in_job  = '0;
		res_ack = 1'b0;
		tb_errs = 0;
		lfsr    = 32'h28863568;
		build_jobs();
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		arst_n = 1'b1;
		repeat (2) begin
			@(posedge clk);
			#1;
		end
		// next request goes up while the last result is still pending
		for (int j = 0; j < N_JOBS; j++)
			send_job(jobs[j]);
		while (acked < N_JOBS)
			@(posedge clk);
		repeat (4) @(posedge clk);
		if (pending != 0) begin
			$display("checker still holds %0d jobs without a result", pending);
			tb_errs++;
		end
		if (res_cnt != N_JOBS) begin
			$display("got %0d results for %0d jobs", res_cnt, N_JOBS);
			tb_errs++;
		end
		$display("errors: %0d mismatches, %0d protocol, %0d end of run",
			mism_cnt, proto_cnt, tb_errs);
		if (mism_cnt + proto_cnt + tb_errs == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// host side of the result handshake
	initial begin
		wait (arst_n === 1'b1);
		forever begin
			do begin
				@(posedge clk);
				#1;
			end while (!res_req);
			repeat (delays[acked]) begin
				@(posedge clk);
				#1;
			end
			res_ack = 1'b1;
			do begin
				@(posedge clk);
				#1;
			end while (res_req);
			res_ack = 1'b0;
			acked++;
		end
	end

	initial begin
		repeat (WATCHDOG) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* mat_mult_top.f */
+incdir+hdl
hdl/mat_types_pkg.sv
hdl/mat_ctrl_pkg.sv
hdl/mat_sequencer.sv
hdl/dot_lane.sv
hdl/mat_assembler.sv
hdl/mat_mult_top.sv
tb/mat_mult_checker.sv
tb/mat_mult_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the matrix multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing -f mat_mult_top.f --top-module mat_mult_tb \
	-Mdir "$BUILD_DIR" -o mat_mult_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

"./$BUILD_DIR/mat_mult_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1
